// File: files.f
+incdir+hw
hw/decodePkg.sv
hw/decodeRa.sv
hw/expandCounter.sv
hw/decodeSequencer.sv
hw/decodeOutReg.sv
hw/decodeStage.sv
tests/decodeTb.sv

// File: run.sh
#!/bin/sh
# Compile the decode stage testbench with Verilator, run it and scan the log.
# Exits non-zero if the build fails, the simulation fails, or the log reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 --top-module decodeTb -Mdir "$BUILD_DIR" -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/VdecodeTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0

// File: tests/decodeTb.sv
/* Random-stimulus testbench for the register-A decode step. Drives words upstream and
   checks every decoded micro-op against a reference model. */
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module decodeTb import decodePkg::*;
();

	localparam int NUM_WORDS = 400;
	// Up to eight micro-ops per word at four cycles each
	localparam int TIMEOUT_CYCLES = NUM_WORDS * 8 * 4;

	logic clk;
	logic rstN;
	operatingModeT om;
	logic inValid;
	logic inReady;
	instrT inInstr;
	logic outValid;
	logic outReady;
	decodedT outDecoded;

	logic [31:0] rngState;
	// Expected micro-ops in output order
	decodedT expQ[$];
	logic pendingImma;
	int errorCount;
	int checkCount;
	int cycleCount = 0;

	decodeStage i_decodeStage (
		.clk(clk), .rstN(rstN), .om(om),
		.inValid(inValid), .inReady(inReady), .inInstr(inInstr),
		.outValid(outValid), .outReady(outReady), .outDecoded(outDecoded)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ends a hung run
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles with %0d micro-ops still expected",
				TIMEOUT_CYCLES, expQ.size());
			$display("Verification failed");
			$finish;
		end
	end

	// ========================================
	// Random numbers and stimulus
	// ========================================

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Random word leaning toward special opcodes and interesting register fields
	function automatic instrT genWord();
		instrT w;
		logic [31:0] r;
		w = nextRand();
		r = nextRand();
		case (r[3:0])
			4'd0, 4'd1: w[`OPC_MSB:`OPC_LSB] = OP_IMMA;
			4'd2, 4'd3: w[`OPC_MSB:`OPC_LSB] = OP_POPM;
			4'd4: w[`OPC_MSB:`OPC_LSB] = OP_RTD;
			4'd5: w[`OPC_MSB:`OPC_LSB] = OP_DBRA;
			// One of the four short-immediate forms
			4'd6, 4'd7: w[`OPC_MSB:`OPC_LSB] = 6'h20 | {4'd0, r[5:4]};
			4'd8, 4'd9: w[`OPC_MSB:`OPC_LSB] = OP_MOV;
			4'd10: w[`OPC_MSB:`OPC_LSB] = OP_ADD;
			default: ;
		endcase
		case (r[9:8])
			2'd0: w[`RA_LSB +: 5] = 5'd31;
			2'd1: w[`RA_LSB +: 5] = 5'd0;
			2'd2: w[`RA_LSB +: 5] = {2'b00, r[12:10]};
			default: ;
		endcase
		// The short-immediate forms read the target field, so aim it at the stack pointer too
		if (r[14:13] == 2'd0)
			w[`RT_LSB +: 5] = 5'd31;
		return w;
	endfunction

	// ========================================
	// Reference model
	// ========================================

	// Return-pop micro-op of register k formed from a pop-multiple word
	function automatic instrT rtdWord(input instrT w, input logic [2:0] k);
		instrT u;
		u = w;
		u[`OPC_MSB:`OPC_LSB] = OP_RTD;
		u[`RA_LSB +: 5] = {2'b00, k};
		return u;
	endfunction

	function automatic decodedT expectUop(input instrT w, input logic imma,
		input operatingModeT mode);
		decodedT d;
		logic [5:0] op;
		logic [2:0] low;
		archRegT r;
		op = w[`OPC_MSB:`OPC_LSB];
		low = w[`RA_LSB +: 3];
		if (imma)
			r = 7'd0;
		else if (op == OP_RTD)
			r = (low == 3'd0) ? 7'd0 : 7'(`RTD_BASE) + {4'd0, low};
		else if (op == OP_DBRA)
			r = 7'(`LOOP_REG);
		else if (op == OP_ADDSI || op == OP_ANDSI || op == OP_ORSI || op == OP_EORSI)
			r = {2'b00, w[`RT_LSB +: 5]};
		else
			r = {2'b00, w[`RA_LSB +: 5]};
		// Encoded stack pointer goes to the bank of the current mode unless it is an extended move
		if (r == 7'(`SP_REG) && !(op == OP_MOV && w[`MOVX_BIT]))
			r = 7'(`SP_BANK_BASE) + {5'd0, mode};
		d.instr = w;
		d.ra = r;
		d.raz = (r == 7'd0);
		d.ran = w[`RAN_BIT];
		d.hasImma = imma;
		return d;
	endfunction

	// Queue the micro-ops that an accepted upstream word must produce
	task automatic acceptWord(input instrT w);
		logic [2:0] cnt;
		int k;
		cnt = w[`RB_LSB +: 3];
		if (w[`OPC_MSB:`OPC_LSB] == OP_IMMA)
			pendingImma = 1'b1;
		else if (w[`OPC_MSB:`OPC_LSB] == OP_POPM)
		begin
			if (cnt == 3'd0)
				expQ.push_back(expectUop(rtdWord(w, 3'd0), pendingImma, om));
			else
				for (k = int'(cnt); k >= 1; k--)
					expQ.push_back(expectUop(rtdWord(w, 3'(k)),
						pendingImma && (k == int'(cnt)), om));
			pendingImma = 1'b0;
		end
		else
		begin
			expQ.push_back(expectUop(w, pendingImma, om));
			pendingImma = 1'b0;
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checkCount++;
		if (got !== want)
		begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, want);
			errorCount++;
		end
	endtask

	task automatic takeOutput();
		decodedT expected;
		if (expQ.size() == 0)
		begin
			$display("Micro-op %h left the DUT at %0t but none was expected", outDecoded, $time);
			errorCount++;
		end
		else
		begin
			expected = expQ.pop_front();
			checkValue("outDecoded.instr", 32'(outDecoded.instr), 32'(expected.instr));
			checkValue("outDecoded.ra", 32'(outDecoded.ra), 32'(expected.ra));
			checkValue("outDecoded.raz", 32'(outDecoded.raz), 32'(expected.raz));
			checkValue("outDecoded.ran", 32'(outDecoded.ran), 32'(expected.ran));
			checkValue("outDecoded.hasImma", 32'(outDecoded.hasImma), 32'(expected.hasImma));
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		instrT curWord;
		logic haveWord;
		int wordsSent;
		logic [31:0] r;
		rngState = 32'h0fb5_7a24;
		rstN = 1'b0;
		om = '0;
		inValid = 1'b0;
		inInstr = '0;
		outReady = 1'b0;
		pendingImma = 1'b0;
		errorCount = 0;
		checkCount = 0;
		curWord = '0;
		haveWord = 1'b0;
		wordsSent = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		while (wordsSent < NUM_WORDS || expQ.size() != 0)
		begin
			@(negedge clk);
			r = nextRand();
			if (!haveWord && wordsSent < NUM_WORDS && r[1:0] != 2'd0)
			begin
				// Mode only moves while no micro-op is in flight
				if (expQ.size() == 0 && r[3:2] == 2'd0)
					om = r[5:4];
				curWord = genWord();
				haveWord = 1'b1;
			end
			inValid = haveWord;
			inInstr = curWord;
			outReady = (r[7:6] != 2'd0);
			// Handshakes are settled one nanosecond before the rising edge
			#4;
			if (outValid && outReady)
				takeOutput();
			if (inValid && inReady)
			begin
				acceptWord(curWord);
				haveWord = 1'b0;
				wordsSent++;
			end
		end
		// Anything that still leaves now would be a duplicate
		repeat (4)
		begin
			@(negedge clk);
			inValid = 1'b0;
			outReady = 1'b1;
			#4;
			if (outValid)
			begin
				$display("Extra micro-op %h left the DUT after all expected ones", outDecoded);
				errorCount++;
			end
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
/* Top of the register-A decode step. Upstream words enter on a valid/ready port and
   decoded micro-ops leave on another. */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*;
(
	input logic clk,
	input logic rstN,
	input operatingModeT om,
	input logic inValid,
	output logic inReady,
	input instrT inInstr,
	output logic outValid,
	input logic outReady,
	output decodedT outDecoded
);

	// Micro-op as formed by the sequencer
	instrT uopInstr;
	logic uopImma;
	logic seqValid;
	logic seqReady;
	// Counter handshake
	logic cntLoad;
	popCountT cntCount;
	logic cntStep;
	popCountT cntIndex;
	logic cntLast;
	// Register-A results
	archRegT ra;
	logic raz;
	logic ran;
	decodedT seqData;

	decodeSequencer i_decodeSequencer (
		.clk(clk), .rstN(rstN),
		.inValid(inValid), .inReady(inReady), .inInstr(inInstr),
		.uopInstr(uopInstr), .uopImma(uopImma),
		.seqValid(seqValid), .seqReady(seqReady),
		.cntLoad(cntLoad), .cntCount(cntCount), .cntStep(cntStep),
		.cntIndex(cntIndex), .cntLast(cntLast)
	);

	expandCounter i_expandCounter (
		.clk(clk), .rstN(rstN),
		.load(cntLoad), .loadCount(cntCount), .step(cntStep),
		.index(cntIndex), .last(cntLast)
	);

	decodeRa i_decodeRa (
		.om(om), .instr(uopInstr), .hasImma(uopImma),
		.ra(ra), .raz(raz), .ran(ran)
	);

	// Bundle the micro-op with its decode for the output register
	assign seqData.instr = uopInstr;
	assign seqData.ra = ra;
	assign seqData.raz = raz;
	assign seqData.ran = ran;
	assign seqData.hasImma = uopImma;

	decodeOutReg i_decodeOutReg (
		.clk(clk), .rstN(rstN),
		.inValid(seqValid), .inReady(seqReady), .inData(seqData),
		.outValid(outValid), .outReady(outReady), .outData(outDecoded)
	);

endmodule

`default_nettype wire

// File: hw/decodeOutReg.sv
/* One-entry valid/ready output register for decoded micro-ops. Accepts a new entry in
   the same cycle the held one leaves, so throughput is one per clock. */
`timescale 1ns/1ps
`default_nettype none

module decodeOutReg import decodePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input decodedT inData,
	output logic outValid,
	input logic outReady,
	output decodedT outData
);

	// Room is available when empty or when the held entry is leaving now
	assign inReady = !outValid || outReady;

	// ========================================
	// Valid flag and payload
	// ========================================

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		// Payload only loads on a real transfer
		if (inReady && inValid)
			outData <= inData;
	end

	// A stalled entry stays put until the consumer takes it
	assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outData)));

endmodule

`default_nettype wire

// File: hw/decodeSequencer.sv
/* Decode sequencer FSM. Absorbs immediate prefixes and expands pop-multiple words into
   return-pop micro-ops, one per register. */
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module decodeSequencer import decodePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input instrT inInstr,
	output instrT uopInstr,
	output logic uopImma,
	output logic seqValid,
	input logic seqReady,
	output logic cntLoad,
	output popCountT cntCount,
	output logic cntStep,
	input popCountT cntIndex,
	input logic cntLast
);

	seqStateT state;
	seqStateT stateNext;
	opcodeT inOp;
	logic isPrefix;
	logic isPopm;
	popCountT inCount;
	// Pop-multiple word kept while the remaining micro-ops go out
	instrT popWord;

	// Rewrite a word as a return-pop of register k
	function automatic instrT fnRtdUop(input instrT word, input popCountT k);
		instrT uop;
		uop = word;
		uop[`OPC_MSB:`OPC_LSB] = OP_RTD;
		uop[`RA_LSB +: $bits(regFieldT)] = regFieldT'(k);
		return uop;
	endfunction

	assign inOp = opcodeT'(inInstr[`OPC_MSB:`OPC_LSB]);
	assign isPrefix = (inOp == OP_IMMA);
	assign isPopm = (inOp == OP_POPM);
	assign inCount = inInstr[`RB_LSB +: $bits(popCountT)];

	// The first micro-op leaves straight away, so the counter starts one below the count
	assign cntCount = inCount - popCountT'(1);

	always_comb
	begin
		stateNext = state;
		inReady = 1'b0;
		seqValid = 1'b0;
		uopInstr = inInstr;
		uopImma = 1'b0;
		cntLoad = 1'b0;
		cntStep = 1'b0;
		case (state)
			sIdle, sPrefixed:
			begin
				uopImma = (state == sPrefixed);
				if (isPrefix)
				begin
					// Prefixes are taken even under back-pressure
					inReady = 1'b1;
					if (inValid)
						stateNext = sPrefixed;
				end
				else
				begin
					inReady = seqReady;
					seqValid = inValid;
					// Highest register of a pop-multiple goes first
					if (isPopm)
						uopInstr = fnRtdUop(inInstr, inCount);
					if (inValid && seqReady)
					begin
						if (isPopm && inCount > popCountT'(1))
						begin
							cntLoad = 1'b1;
							stateNext = sExpand;
						end
						else
							stateNext = sIdle;
					end
				end
			end
			sExpand:
			begin
				// Upstream stalls until the last micro-op is taken
				seqValid = 1'b1;
				uopInstr = fnRtdUop(popWord, cntIndex);
				if (seqReady)
				begin
					cntStep = 1'b1;
					if (cntLast)
						stateNext = sIdle;
				end
			end
			default:
				stateNext = sIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state <= sIdle;
		else
			state <= stateNext;
	end

	always_ff @(posedge clk)
	begin
		if (cntLoad)
			popWord <= inInstr;
	end

	// A non-zero counter means an expansion is running, and upstream stays stalled meanwhile
	assert property (@(posedge clk) disable iff (!rstN)
		(cntIndex != '0) |-> (state == sExpand && !inReady));

	// A prefix being consumed never produces a micro-op of its own
	assert property (@(posedge clk) disable iff (!rstN)
		(inValid && inReady && isPrefix) |-> !seqValid);

endmodule

`default_nettype wire

// File: hw/expandCounter.sv
/* Down-counter for pop-multiple expansion. Holds the register index of the next
   micro-op and flags the last one. */
`timescale 1ns/1ps
`default_nettype none

module expandCounter import decodePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic load,
	input popCountT loadCount,
	input logic step,
	output popCountT index,
	output logic last
);

	// ========================================
	// Index register
	// ========================================

	// Load wins over step; the sequencer never raises both together
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			index <= '0;
		else if (load)
			index <= loadCount;
		else if (step)
			index <= index - popCountT'(1);
	end

	// Index one is the final micro-op; zero only occurs when idle
	assign last = (index <= popCountT'(1));

	// The sequencer must stop stepping once the count is used up
	assert property (@(posedge clk) disable iff (!rstN)
		step |-> (index != '0));

endmodule

`default_nettype wire

// File: hw/decodeRa.sv
/* Combinational register-A decoder. Maps an instruction to its architectural A register,
   applying prefix, opcode remapping and banked stack pointer. */
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module decodeRa import decodePkg::*;
(
	input operatingModeT om,
	input instrT instr,
	input logic hasImma,
	output archRegT ra,
	output logic raz,
	output logic ran
);

	opcodeT op;
	archRegT raSel;

	assign op = opcodeT'(instr[`OPC_MSB:`OPC_LSB]);

	// Opcode-dependent selection before stack-pointer banking
	function automatic archRegT fnRa(input instrT ir, input logic imma);
		opcodeT irOp;
		popCountT rtdCount;
		irOp = opcodeT'(ir[`OPC_MSB:`OPC_LSB]);
		rtdCount = ir[`RA_LSB +: $bits(popCountT)];
		// An immediate prefix replaces the A operand, so no register is read
		if (imma)
			return '0;
		case (irOp)
			// Return-pop reads one of eight registers; count zero means no register
			OP_RTD:
				return (rtdCount == '0) ? archRegT'(0) :
					archRegT'(`RTD_BASE) + archRegT'(rtdCount);
			// Decrement-and-branch always reads the loop counter
			OP_DBRA:
				return archRegT'(`LOOP_REG);
			// Short-immediate forms take their source from the target field
			OP_ADDSI, OP_ANDSI, OP_ORSI, OP_EORSI:
				return archRegT'(ir[`RT_LSB +: $bits(regFieldT)]);
			default:
				return archRegT'(ir[`RA_LSB +: $bits(regFieldT)]);
		endcase
	endfunction

	assign raSel = fnRa(instr, hasImma);

	always_comb
	begin
		ra = raSel;
		// Register 31 is the stack pointer of the current mode, except in an extended move
		if (raSel == archRegT'(`SP_REG) && !(op == OP_MOV && instr[`MOVX_BIT]))
			ra = archRegT'(`SP_BANK_BASE) + archRegT'(om);
	end

	// Zero register flag follows the final number
	assign raz = (ra == '0);
	assign ran = instr[`RAN_BIT];

endmodule

`default_nettype wire

// File: hw/decodePkg.sv
/* Shared types for the register-A decode step: widths, opcodes, FSM states and the
   decoded micro-op that travels downstream. */
`default_nettype none

package decodePkg;

	// ========================================
	// Plain vectors with a meaning
	// ========================================

	// One 32-bit instruction word
	typedef logic [31:0] instrT;
	// Register number as encoded in an instruction field
	typedef logic [4:0] regFieldT;
	// Architectural register number after banking and remapping
	typedef logic [6:0] archRegT;
	// Operating mode picks one of four stack pointers
	typedef logic [1:0] operatingModeT;
	// Index of a micro-op within a pop-multiple
	typedef logic [2:0] popCountT;

	// ========================================
	// Encodings
	// ========================================

	// Opcodes that the decoder treats specially; anything else is a generic register form
	typedef enum logic [5:0] {
		OP_ADD   = 6'h02,
		OP_MOV   = 6'h03,
		OP_IMMA  = 6'h0A,
		OP_RTD   = 6'h10,
		OP_POPM  = 6'h11,
		OP_DBRA  = 6'h12,
		OP_ADDSI = 6'h20,
		OP_ANDSI = 6'h21,
		OP_ORSI  = 6'h22,
		OP_EORSI = 6'h23
	} opcodeT;

	// Sequencer FSM states
	typedef enum logic [1:0] {
		sIdle,
		sPrefixed,
		sExpand
	} seqStateT;

	// Decoded micro-op, 42 bits
	typedef struct packed {
		instrT instr;
		archRegT ra;
		logic raz;
		logic ran;
		logic hasImma;
	} decodedT;

endpackage

`default_nettype wire

// File: hw/decode_settings.svh
/* Instruction field positions and special register numbers for the register-A decode step.
   Included by every RTL module that picks fields out of an instruction word. */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Opcode sits in the low six bits
`define OPC_LSB 0
`define OPC_MSB 5
// Register fields, each five bits wide
`define RT_LSB 6
`define RA_LSB 11
`define RB_LSB 16
// Single-bit flags
`define RAN_BIT 21
`define MOVX_BIT 31

// Special architectural register numbers
`define SP_REG 31
`define SP_BANK_BASE 32
`define RTD_BASE 40
`define LOOP_REG 55

`endif
